// File: rtl/tcb_params.svh
// tightly coupled bus parameters
// bus widths, memory size and the memory stall pattern
// shared by the RTL and the testbench

`ifndef TCB_PARAMS_SVH
`define TCB_PARAMS_SVH

////////////////////////////////////////
// bus widths
////////////////////////////////////////

// byte address width
`define TCB_ADR_W 10
// bytes per data word
`define TCB_BYT 4
`define TCB_DAT_W (8*`TCB_BYT)

////////////////////////////////////////
// memory subordinate
////////////////////////////////////////

// words, covers the full address range
`define TCB_MEM_DEPTH 256
// ready low for STALL_LEN out of every STALL_PERIOD cycles
`define TCB_STALL_LEN 3
`define TCB_STALL_PERIOD 7

`endif

// File: rtl/tcb_pkg.sv
// tightly coupled bus types
// request and response payloads, bus opcodes and
// the capture strategy of the register slice

`include "tcb_params.svh"

package tcb_pkg;

    ////////////////////////////////////////
    // enumerations
    ////////////////////////////////////////

    // bus operation
    typedef enum logic {op_read, op_write} tcb_op_t;

    // register slice buffer strategy
    // power loads only enabled write bytes
    typedef enum logic {opt_power, opt_complexity} tcb_opt_t;

    ////////////////////////////////////////
    // payloads
    ////////////////////////////////////////

    // request, held stable by the manager until rdy
    typedef struct packed {
        tcb_op_t                op;
        logic [`TCB_ADR_W-1:0]  adr;
        logic [`TCB_BYT-1:0]    byt;
        logic [`TCB_DAT_W-1:0]  wdt;
    } tcb_req_t;

    // response, one cycle strobe with no back-pressure
    typedef struct packed {
        logic                   vld;
        logic [`TCB_DAT_W-1:0]  rdt;
        // misaligned access
        logic                   err;
    } tcb_rsp_t;

endpackage

// File: rtl/tcb_register_backpressure.sv
// bus register slice on the back-pressure path
// sub_rdy comes from a flop, so the ready path from the
// subordinate side is cut. a request met by a stalled
// downstream is parked in a one-entry buffer and replayed

`include "tcb_params.svh"

module tcb_register_backpressure #(
    parameter tcb_pkg::tcb_opt_t opt = tcb_pkg::opt_power
)(
    input  logic              sub,
    input  logic              reset,
    input  logic              sub_vld,
    input  tcb_pkg::tcb_req_t sub_req,
    input  logic              man_rdy,
    output logic              sub_rdy,
    output logic              man_vld,
    output tcb_pkg::tcb_req_t man_req
);

    // buffer load strobe
    logic tmp_trn;

    // buffered request fields
    tcb_pkg::tcb_op_t      tmp_op;
    logic [`TCB_ADR_W-1:0] tmp_adr;
    logic [`TCB_BYT-1:0]   tmp_byt;
    logic [`TCB_DAT_W-1:0] tmp_wdt;
    tcb_pkg::tcb_req_t     tmp_req;

    // man side request with unused write bytes zeroed
    tcb_pkg::tcb_req_t     man_req_vis;

    ////////////////////////////////////////
    // handshake
    ////////////////////////////////////////

    // transfer accepted here while downstream stalls
    assign tmp_trn = sub_vld & sub_rdy & ~man_rdy;

    // buffer full keeps vld up
    assign man_vld = sub_rdy ? sub_vld : 1'b1;

    // drops after a capture, rises once the buffer drains
    always_ff @(posedge sub) begin
        if (reset) begin
            sub_rdy <= 1'b1;
        end else if (sub_rdy) begin
            sub_rdy <= ~(sub_vld & ~man_rdy);
        end else begin
            sub_rdy <= man_rdy;
        end
    end

    ////////////////////////////////////////
    // request buffer
    ////////////////////////////////////////

    // control fields
    always_ff @(posedge sub) begin
        if (tmp_trn) begin
            tmp_op  <= sub_req.op;
            tmp_adr <= sub_req.adr;
            tmp_byt <= sub_req.byt;
        end
    end

    // write data lanes loaded only for writes
    generate
        if (opt == tcb_pkg::opt_power) begin : g_power
            // disabled lanes keep their old value to save toggling
            always_ff @(posedge sub) begin
                if (tmp_trn && sub_req.op == tcb_pkg::op_write) begin
                    for (int i = 0; i < `TCB_BYT; i++) begin
                        if (sub_req.byt[i]) begin
                            tmp_wdt[i*8 +: 8] <= sub_req.wdt[i*8 +: 8];
                        end
                    end
                end
            end
        end else begin : g_complexity
            // whole word on every buffered write
            always_ff @(posedge sub) begin
                if (tmp_trn && sub_req.op == tcb_pkg::op_write) begin
                    tmp_wdt <= sub_req.wdt;
                end
            end
        end
    endgenerate

    assign tmp_req = '{op: tmp_op, adr: tmp_adr, byt: tmp_byt, wdt: tmp_wdt};

    // live request while ready and the buffer otherwise
    assign man_req = sub_rdy ? sub_req : tmp_req;

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // only bytes the subordinate actually consumes
    function automatic tcb_pkg::tcb_req_t req_visible(tcb_pkg::tcb_req_t req);
        tcb_pkg::tcb_req_t vis;
        vis = req;
        for (int i = 0; i < `TCB_BYT; i++) begin
            if (req.op != tcb_pkg::op_write || !req.byt[i]) begin
                vis.wdt[i*8 +: 8] = 8'h00;
            end
        end
        return vis;
    endfunction

    assign man_req_vis = req_visible(man_req);

    // manager keeps a request that meets a full buffer
    a_sub_hold: assert property (@(posedge sub) disable iff (reset)
        sub_vld && !sub_rdy |=> sub_vld && $stable(sub_req));

    // stalled request stays put across the live to buffer switch
    a_man_hold: assert property (@(posedge sub) disable iff (reset)
        man_vld && !man_rdy |=> man_vld && $stable(man_req_vis));

endmodule

// File: rtl/tcb_memory.sv
// bus memory subordinate
// word array with byte enable writes and a registered
// response one cycle after each transfer. ready follows a
// fixed periodic stall pattern from a free running counter

`include "tcb_params.svh"

module tcb_memory (
    input  logic              sub,
    input  logic              reset,
    input  logic              vld,
    input  tcb_pkg::tcb_req_t req,
    output logic              rdy,
    output tcb_pkg::tcb_rsp_t rsp
);

    localparam int CNT_W = $clog2(`TCB_STALL_PERIOD);
    // byte offset bits within a word
    localparam int LSB   = $clog2(`TCB_BYT);
    localparam int IDX_W = $clog2(`TCB_MEM_DEPTH);

    // stall pattern
    logic [CNT_W-1:0] stall_cnt;

    // decoded transfer
    logic             trn;
    logic [IDX_W-1:0] idx;
    logic             mis;

    // storage
    logic [`TCB_DAT_W-1:0] mem [`TCB_MEM_DEPTH];

    // response register
    logic                  rsp_vld;
    logic [`TCB_DAT_W-1:0] rsp_rdt;
    logic                  rsp_err;

    ////////////////////////////////////////
    // stall generator
    ////////////////////////////////////////

    // counts 0 .. PERIOD-1 then wraps
    always_ff @(posedge sub) begin
        if (reset) begin
            stall_cnt <= '0;
        end else if (stall_cnt == CNT_W'(`TCB_STALL_PERIOD - 1)) begin
            stall_cnt <= '0;
        end else begin
            stall_cnt <= stall_cnt + 1'b1;
        end
    end

    // ready at the start of each period and stalled at the end
    assign rdy = (stall_cnt < CNT_W'(`TCB_STALL_PERIOD - `TCB_STALL_LEN));

    ////////////////////////////////////////
    // access
    ////////////////////////////////////////

    assign trn = vld & rdy;
    assign idx = req.adr[LSB +: IDX_W];
    // any low address bit set
    assign mis = |req.adr[LSB-1:0];

    // byte lane writes with misaligned ones dropped
    always_ff @(posedge sub) begin
        if (trn && req.op == tcb_pkg::op_write && !mis) begin
            for (int i = 0; i < `TCB_BYT; i++) begin
                if (req.byt[i]) begin
                    mem[idx][i*8 +: 8] <= req.wdt[i*8 +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////
    // response
    ////////////////////////////////////////

    // strobe
    always_ff @(posedge sub) begin
        if (reset) begin
            rsp_vld <= 1'b0;
        end else begin
            rsp_vld <= trn;
        end
    end

    // payload with zero data on writes and errors
    always_ff @(posedge sub) begin
        if (trn) begin
            rsp_err <= mis;
            rsp_rdt <= (req.op == tcb_pkg::op_read && !mis) ? mem[idx] : '0;
        end
    end

    assign rsp = '{vld: rsp_vld, rdt: rsp_rdt, err: rsp_err};

    // a stalled request stays offered with the same control fields
    a_req_hold: assert property (@(posedge sub) disable iff (reset)
        vld && !rdy |=> vld && $stable(req.op) && $stable(req.adr) && $stable(req.byt));

endmodule

// File: rtl/tcb_subsystem.sv
// bus subsystem top level
// register slice in front of the stalling memory
// the response goes from the memory straight to the port

`include "tcb_params.svh"

module tcb_subsystem (
    input  logic              sub,
    input  logic              reset,
    input  logic              vld,
    input  tcb_pkg::tcb_req_t req,
    output logic              rdy,
    output tcb_pkg::tcb_rsp_t rsp
);

    // slice to memory request channel
    logic              man_vld;
    tcb_pkg::tcb_req_t man_req;
    logic              man_rdy;

    // ready path cut here
    tcb_register_backpressure #(
        .opt     (tcb_pkg::opt_power)
    ) slice (
        .sub     (sub),
        .reset   (reset),
        .sub_vld (vld),
        .sub_req (req),
        .man_rdy (man_rdy),
        .sub_rdy (rdy),
        .man_vld (man_vld),
        .man_req (man_req)
    );

    // storage, answers one cycle after each transfer
    tcb_memory memory (
        .sub     (sub),
        .reset   (reset),
        .vld     (man_vld),
        .req     (man_req),
        .rdy     (man_rdy),
        .rsp     (rsp)
    );

endmodule

// File: bench/tcb_subsystem_tb.sv
// testbench for the bus subsystem
// directed table of requests, then random traffic from an LCG
// expected responses come from the table or a reference memory
// and are checked in order as the response strobes arrive

`include "tcb_params.svh"

module tcb_subsystem_tb;

    localparam int N_TBL      = 18;
    localparam int N_RAND     = 64;
    localparam int MAX_CYCLES = 20 * (N_TBL + N_RAND) + 100;
    // byte offset bits within a word
    localparam int LSB        = $clog2(`TCB_BYT);

    // one directed step with its expected response
    typedef struct packed {
        tcb_pkg::tcb_op_t      op;
        logic [`TCB_ADR_W-1:0] adr;
        logic [`TCB_BYT-1:0]   byt;
        logic [`TCB_DAT_W-1:0] wdt;
        logic [`TCB_DAT_W-1:0] rdt;
        logic                  err;
    } step_t;

    logic              sub;
    logic              reset;
    logic              vld;
    tcb_pkg::tcb_req_t req;
    logic              rdy;
    tcb_pkg::tcb_rsp_t rsp;

    // expected responses in request order
    tcb_pkg::tcb_rsp_t exp_q [$];
    string             name_q [$];
    int                n_req = 0;
    int                n_rsp = 0;
    int                cycles = 0;
    logic [31:0]       rng_state = 32'hdd0e;

    // reference memory and a mask of bytes written so far
    logic [`TCB_DAT_W-1:0] ref_mem [`TCB_MEM_DEPTH];
    logic [`TCB_BYT-1:0]   ref_known [`TCB_MEM_DEPTH];

    // op, adr, byt, wdt, expected rdt, expected err
    step_t steps [N_TBL] = '{
        // full word write and read back
        '{tcb_pkg::op_write, 10'h010, 4'hf, 32'hdeadbeef, 32'h0, 1'b0},
        '{tcb_pkg::op_read,  10'h010, 4'hf, 32'h0,        32'hdeadbeef, 1'b0},
        // partial writes merge into one word
        '{tcb_pkg::op_write, 10'h020, 4'hf, 32'h11223344, 32'h0, 1'b0},
        '{tcb_pkg::op_write, 10'h020, 4'h3, 32'haaaabbcc, 32'h0, 1'b0},
        '{tcb_pkg::op_write, 10'h020, 4'h8, 32'h55eeeeee, 32'h0, 1'b0},
        '{tcb_pkg::op_write, 10'h020, 4'h4, 32'h00660000, 32'h0, 1'b0},
        '{tcb_pkg::op_read,  10'h020, 4'hf, 32'h0,        32'h5566bbcc, 1'b0},
        // misaligned accesses leave the word alone
        '{tcb_pkg::op_write, 10'h022, 4'hf, 32'hffffffff, 32'h0, 1'b1},
        '{tcb_pkg::op_read,  10'h021, 4'hf, 32'h0,        32'h0, 1'b1},
        '{tcb_pkg::op_read,  10'h020, 4'hf, 32'h0,        32'h5566bbcc, 1'b0},
        // burst across the stall windows
        '{tcb_pkg::op_write, 10'h030, 4'hf, 32'h01010101, 32'h0, 1'b0},
        '{tcb_pkg::op_write, 10'h034, 4'hf, 32'h02020202, 32'h0, 1'b0},
        '{tcb_pkg::op_write, 10'h038, 4'hf, 32'h03030303, 32'h0, 1'b0},
        '{tcb_pkg::op_write, 10'h03c, 4'hf, 32'h04040404, 32'h0, 1'b0},
        '{tcb_pkg::op_read,  10'h030, 4'hf, 32'h0,        32'h01010101, 1'b0},
        '{tcb_pkg::op_read,  10'h034, 4'hf, 32'h0,        32'h02020202, 1'b0},
        '{tcb_pkg::op_read,  10'h038, 4'hf, 32'h0,        32'h03030303, 1'b0},
        '{tcb_pkg::op_read,  10'h03c, 4'hf, 32'h0,        32'h04040404, 1'b0}
    };

    tcb_subsystem dut (
        .sub   (sub),
        .reset (reset),
        .vld   (vld),
        .req   (req),
        .rdy   (rdy),
        .rsp   (rsp)
    );

    ////////////////////////////////////////
    // clock and watchdog
    ////////////////////////////////////////

    initial begin
        sub = 1'b0;
        forever #50 sub = ~sub;
    end

    always @(posedge sub) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            abort_run($sformatf("timeout after %0d cycles, %0d responses missing",
                                cycles, exp_q.size()));
        end
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    // next 16 random bits from the upper half of the LCG state
    function automatic logic [15:0] rand_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[31:16];
    endfunction

    // memory rules with err on low address bits and zero write data
    function automatic tcb_pkg::tcb_rsp_t model_access(input tcb_pkg::tcb_req_t r);
        tcb_pkg::tcb_rsp_t e;
        logic [7:0]        w;
        w = r.adr[LSB +: 8];
        e = '{vld: 1'b1, rdt: '0, err: |r.adr[LSB-1:0]};
        if (!e.err && r.op == tcb_pkg::op_write) begin
            for (int i = 0; i < `TCB_BYT; i++) begin
                if (r.byt[i]) begin
                    ref_mem[w][i*8 +: 8] = r.wdt[i*8 +: 8];
                    ref_known[w][i] = 1'b1;
                end
            end
        end else if (!e.err) begin
            e.rdt = ref_mem[w];
        end
        return e;
    endfunction

    task automatic check_rsp(input string name, input tcb_pkg::tcb_rsp_t exp,
                             input tcb_pkg::tcb_rsp_t act);
        if (act.rdt !== exp.rdt || act.err !== exp.err) begin
            abort_run($sformatf("error %s: expected rdt %h err %b, actual rdt %h err %b",
                                name, exp.rdt, exp.err, act.rdt, act.err));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("error %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // prints an error line on a mismatch and returns whether counts agree
    function automatic bit check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("error %s: expected %0d, actual %0d", name, exp, act);
        end
        return act == exp;
    endfunction

    // 0 to 2 idle cycles from a falling edge
    task automatic idle_gap();
        repeat (rand_next() % 3) @(negedge sub);
    endtask

    // hold the request until the registered rdy is seen high
    task automatic send(input tcb_pkg::tcb_req_t r, input tcb_pkg::tcb_rsp_t e,
                        input string name);
        vld = 1'b1;
        req = r;
        while (!rdy) @(negedge sub);
        exp_q.push_back(e);
        name_q.push_back(name);
        n_req = n_req + 1;
        // transfer on the rising edge in between
        @(negedge sub);
        vld = 1'b0;
    endtask

    ////////////////////////////////////////
    // response monitor
    ////////////////////////////////////////

    // every strobe counts, surplus ones show up in the final count
    always @(negedge sub) begin
        if (!reset && rsp.vld) begin
            n_rsp = n_rsp + 1;
            if (exp_q.size() != 0) begin
                check_rsp(name_q.pop_front(), exp_q.pop_front(), rsp);
            end
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin : stimulus
        tcb_pkg::tcb_req_t r;
        tcb_pkg::tcb_rsp_t e;
        logic [15:0]       bits;
        logic [7:0]        w;
        reset = 1'b1;
        vld = 1'b0;
        req = '0;
        for (int i = 0; i < `TCB_MEM_DEPTH; i++) begin
            ref_known[i] = '0;
        end
        repeat (3) @(posedge sub);
        @(negedge sub);
        reset = 1'b0;
        check_bit("reset rdy", 1'b1, rdy);
        check_bit("reset rsp vld", 1'b0, rsp.vld);

        // directed table with the model kept in step
        for (int i = 0; i < N_TBL; i++) begin
            r = '{op: steps[i].op, adr: steps[i].adr, byt: steps[i].byt, wdt: steps[i].wdt};
            e = '{vld: 1'b1, rdt: steps[i].rdt, err: steps[i].err};
            void'(model_access(r));
            idle_gap();
            send(r, e, $sformatf("table[%0d]", i));
        end

        // random traffic in a 16 word window
        for (int i = 0; i < N_RAND; i++) begin
            bits = rand_next();
            w = {4'h4, bits[3:0]};
            r.op = bits[4] ? tcb_pkg::op_write : tcb_pkg::op_read;
            r.adr = {w, 2'b00};
            // one in eight misaligned
            if (bits[7:5] == 3'b000) begin
                r.adr[1:0] = bits[9:8] | 2'b01;
            end
            r.byt = bits[13:10];
            r.wdt = {rand_next(), rand_next()};
            // aligned reads only of fully written words
            if (r.op == tcb_pkg::op_read && r.adr[1:0] == 2'b00 && ref_known[w] != 4'hf) begin
                r.op = tcb_pkg::op_write;
                r.byt = 4'hf;
            end
            e = model_access(r);
            idle_gap();
            send(r, e, $sformatf("random[%0d]", i));
        end

        // drain and then watch a few cycles for extra strobes
        while (exp_q.size() != 0) @(negedge sub);
        repeat (4) @(posedge sub);
        if (check_count("response count", n_req, n_rsp)) begin
            $display("test passed");
            $finish;
        end else begin
            abort_run("response count does not match the request count");
        end
    end

endmodule

// File: build.f
+incdir+rtl
rtl/tcb_pkg.sv
rtl/tcb_register_backpressure.sv
rtl/tcb_memory.sv
rtl/tcb_subsystem.sv
bench/tcb_subsystem_tb.sv

// File: Makefile
# Verilator build and run for the bus subsystem testbench
# every variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tcb_subsystem_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --assert -j $(JOBS)

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := rtl/tcb_params.svh

.PHONY: all compile run clean

all: run

# build the simulation executable
compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# exit status is nonzero when the testbench stops with $fatal
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
